//--- logic/be_pkt_pkg.sv
// Back-end internal packets exchanged between execute, commit, issue and the director
// Imported by the RTL and the testbench for the packet types and address widths

package be_pkt_pkg;

  localparam int vaddr_width_c = 39;
  localparam int bmeta_width_c = 16;

  typedef enum logic [1:0]
  {
    e_priv_user       = 2'd0
    , e_priv_supervisor = 2'd1
    , e_priv_machine    = 2'd3
  } priv_e;

  // Resolved next PC from execute stage 1
  typedef struct packed
  {
    logic                     v;
    logic [vaddr_width_c-1:0] npc;
    logic                     branch;
    logic                     btaken;
  } branch_pkt_s;

  // Architectural events and the next PC from commit
  typedef struct packed
  {
    logic                     npc_w_v;
    logic [vaddr_width_c-1:0] npc;
    logic                     exception;
    logic                     interrupt;
    logic                     eret;
    logic                     wfi;
    logic                     fencei;
    logic                     icache_miss;
    priv_e                    priv_n;
  } commit_pkt_s;

  // Instruction currently leaving the issue stage
  typedef struct packed
  {
    logic                     v;
    logic [vaddr_width_c-1:0] pc;
    logic [bmeta_width_c-1:0] bmeta;
  } isd_status_s;

endpackage

//--- logic/fe_cmd_pkg.sv
// Command format sent from the back end to the front end
// The operand word is read as redirect or attaboy operands depending on the opcode

package fe_cmd_pkg;

  typedef enum logic [2:0]
  {
    e_op_state_reset            = 3'd0
    , e_op_pc_redirection       = 3'd1
    , e_op_icache_fill_response = 3'd2
    , e_op_icache_fence         = 3'd3
    , e_op_wait                 = 3'd4
    , e_op_attaboy              = 3'd5
  } fe_opcode_e;

  typedef enum logic [1:0]
  {
    e_subop_trap                = 2'd0
    , e_subop_eret              = 2'd1
    , e_subop_branch_mispredict = 2'd2
  } redirect_subop_e;

  typedef enum logic [1:0]
  {
    e_not_a_branch           = 2'd0
    , e_incorrect_pred_taken  = 2'd1
    , e_incorrect_pred_ntaken = 2'd2
  } mispredict_reason_e;

  typedef struct packed
  {
    redirect_subop_e                      subop;
    be_pkt_pkg::priv_e                    priv;
    mispredict_reason_e                   reason;
    logic [be_pkt_pkg::bmeta_width_c-1:0] bmeta;
  } redirect_ops_s;

  // Attaboy needs fewer bits so it is padded on top to line up with redirect
  localparam int attaboy_pad_width_c = $bits(redirect_ops_s) - 1 - be_pkt_pkg::bmeta_width_c;

  typedef struct packed
  {
    logic [attaboy_pad_width_c-1:0]       pad;
    logic                                 taken;
    logic [be_pkt_pkg::bmeta_width_c-1:0] bmeta;
  } attaboy_ops_s;

  typedef union packed
  {
    redirect_ops_s redirect;
    attaboy_ops_s  attaboy;
  } fe_cmd_operands_u;

  typedef struct packed
  {
    fe_opcode_e                           opcode;
    logic [be_pkt_pkg::vaddr_width_c-1:0] vaddr;
    fe_cmd_operands_u                     operands;
  } fe_cmd_s;

endpackage

//--- logic/npc_tracker.sv
`timescale 1ns/1ps

// Tracks the next PC the back end expects and flags issuing instructions that miss it
// Also remembers whether the last resolved instruction was a (taken) branch

module npc_tracker
  #(parameter logic [be_pkt_pkg::vaddr_width_c-1:0] boot_pc_p = '0)
  (input                                          clk_i
   , input                                        reset_i
   , input be_pkt_pkg::branch_pkt_s               br_pkt_i
   , input be_pkt_pkg::commit_pkt_s               commit_pkt_i
   , input be_pkt_pkg::isd_status_s               isd_status_i
   , output logic [be_pkt_pkg::vaddr_width_c-1:0] expected_npc_o
   , output logic                                 npc_mismatch_o
   , output logic                                 last_branch_o
   , output logic                                 last_btaken_o
   );

  import be_pkt_pkg::*;

  logic [vaddr_width_c-1:0] npc_r;
  logic [vaddr_width_c-1:0] npc_n;
  logic                     npc_w_v;
  logic                     branch_pending_r;
  logic                     btaken_pending_r;

  // Commit wins over execute since it reflects architectural state
  assign npc_w_v = commit_pkt_i.npc_w_v | br_pkt_i.v;
  assign npc_n   = commit_pkt_i.npc_w_v ? commit_pkt_i.npc : br_pkt_i.npc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      npc_r <= boot_pc_p;
    else if (npc_w_v)
      npc_r <= npc_n;
  end

  // Bypass so an update is seen by issue in the same cycle
  assign expected_npc_o = npc_w_v ? npc_n : npc_r;
  assign npc_mismatch_o = isd_status_i.v & (expected_npc_o != isd_status_i.pc);

  // Set by a resolved branch, cleared by the next issue
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      branch_pending_r <= 1'b0;
      btaken_pending_r <= 1'b0;
    end
    else if (isd_status_i.v)
    begin
      branch_pending_r <= 1'b0;
      btaken_pending_r <= 1'b0;
    end
    else
    begin
      branch_pending_r <= branch_pending_r | br_pkt_i.branch;
      btaken_pending_r <= btaken_pending_r | br_pkt_i.btaken;
    end
  end

  // A branch resolving this cycle counts for an instruction issuing this cycle
  assign last_branch_o = branch_pending_r | br_pkt_i.branch;
  assign last_btaken_o = btaken_pending_r | br_pkt_i.btaken;

  // Execute must never report a taken non-branch
  a_btaken_is_branch: assert property (@(posedge clk_i) disable iff (reset_i)
    br_pkt_i.btaken |-> br_pkt_i.branch);

endmodule

//--- logic/cmd_arbiter.sv
`timescale 1ns/1ps

// Director FSM and priority selection of the next FE command
// A command is offered to the FE command FIFO only while the FIFO has room

module cmd_arbiter
  (input                                         clk_i
   , input                                       reset_i
   , input                                       freeze_i
   , input                                       irq_waiting_i
   , input be_pkt_pkg::commit_pkt_s              commit_pkt_i
   , input be_pkt_pkg::isd_status_s              isd_status_i
   , input [be_pkt_pkg::vaddr_width_c-1:0]       expected_npc_i
   , input                                       npc_mismatch_i
   , input                                       last_branch_i
   , input                                       last_btaken_i
   , input                                       fifo_ready_i
   , input                                       fe_cmd_v_i
   , output fe_cmd_pkg::fe_cmd_s                 cmd_o
   , output logic                                cmd_v_o
   , output logic                                suppress_iss_o
   );

  import fe_cmd_pkg::*;

  typedef enum logic [4:0]
  {
    s_reset   = 5'b00001
    , s_boot  = 5'b00010
    , s_run   = 5'b00100
    , s_fence = 5'b01000
    , s_wait  = 5'b10000
  } state_e;

  state_e        state_r;
  state_e        state_n;
  logic          cmd_sel;
  logic          nonattaboy_v;
  redirect_ops_s redirect_ops;

  // Any command except attaboy leaves the FE needing a fence
  assign nonattaboy_v = cmd_v_o & (cmd_o.opcode != e_op_attaboy);

  always_comb
  begin
    case (state_r)
      s_reset: state_n = freeze_i ? s_reset : s_boot;
      s_boot:  state_n = cmd_v_o ? s_run : s_boot;
      s_run:   state_n = commit_pkt_i.wfi ? s_wait : (nonattaboy_v ? s_fence : s_run);
      s_fence: state_n = fe_cmd_v_i ? s_fence : s_run;
      s_wait:  state_n = nonattaboy_v ? s_fence : s_wait;
      default: state_n = s_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= s_reset;
    else
      state_r <= state_n;
  end

  // Hold issue while the FE still has commands to digest
  assign suppress_iss_o = ((state_r == s_fence) & fe_cmd_v_i) | (state_r == s_wait);

  always_comb
  begin
    cmd_o        = '0;
    cmd_sel      = 1'b0;
    redirect_ops = '0;

    // Nothing goes out before boot
    if (state_r == s_reset)
      cmd_sel = 1'b0;
    else if (state_r == s_boot)
    begin
      cmd_o.opcode                   = e_op_state_reset;
      cmd_o.vaddr                    = expected_npc_i;
      redirect_ops.priv              = commit_pkt_i.priv_n;
      cmd_o.operands.redirect        = redirect_ops;
      cmd_sel                        = 1'b1;
    end
    else if (commit_pkt_i.wfi)
    begin
      cmd_o.opcode = e_op_wait;
      cmd_o.vaddr  = commit_pkt_i.npc;
      cmd_sel      = 1'b1;
    end
    else if (commit_pkt_i.fencei)
    begin
      cmd_o.opcode = e_op_icache_fence;
      cmd_o.vaddr  = commit_pkt_i.npc;
      cmd_sel      = 1'b1;
    end
    else if (commit_pkt_i.icache_miss)
    begin
      cmd_o.opcode = e_op_icache_fill_response;
      cmd_o.vaddr  = commit_pkt_i.npc;
      cmd_sel      = 1'b1;
    end
    else if (commit_pkt_i.eret)
    begin
      cmd_o.opcode            = e_op_pc_redirection;
      cmd_o.vaddr             = commit_pkt_i.npc;
      redirect_ops.subop      = e_subop_eret;
      redirect_ops.priv       = commit_pkt_i.priv_n;
      cmd_o.operands.redirect = redirect_ops;
      cmd_sel                 = 1'b1;
    end
    else if (commit_pkt_i.exception | commit_pkt_i.interrupt
             | ((state_r == s_wait) & irq_waiting_i))
    begin
      cmd_o.opcode            = e_op_pc_redirection;
      cmd_o.vaddr             = commit_pkt_i.npc;
      redirect_ops.subop      = e_subop_trap;
      redirect_ops.priv       = commit_pkt_i.priv_n;
      cmd_o.operands.redirect = redirect_ops;
      cmd_sel                 = 1'b1;
    end
    else if (npc_mismatch_i)
    begin
      // FE went the wrong way so send it to the NPC we expect
      cmd_o.opcode            = e_op_pc_redirection;
      cmd_o.vaddr             = expected_npc_i;
      redirect_ops.subop      = e_subop_branch_mispredict;
      redirect_ops.bmeta      = isd_status_i.bmeta;
      redirect_ops.reason     = last_branch_i
                                ? (last_btaken_i ? e_incorrect_pred_taken
                                                 : e_incorrect_pred_ntaken)
                                : e_not_a_branch;
      cmd_o.operands.redirect = redirect_ops;
      cmd_sel                 = 1'b1;
    end
    else if (isd_status_i.v & last_branch_i)
    begin
      // Correct prediction for the FE to train on
      cmd_o.opcode                 = e_op_attaboy;
      cmd_o.vaddr                  = expected_npc_i;
      cmd_o.operands.attaboy.taken = last_btaken_i;
      cmd_o.operands.attaboy.bmeta = isd_status_i.bmeta;
      cmd_sel                      = 1'b1;
    end
  end

  // A command finding the FIFO full is dropped
  assign cmd_v_o = cmd_sel & fifo_ready_i;

  // Fence exit relies on a FIFO without room still showing a command
  a_full_fifo_has_head: assert property (@(posedge clk_i) disable iff (reset_i)
    !fifo_ready_i |-> fe_cmd_v_i);

  a_state_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot(state_r));

endmodule

//--- logic/fe_cmd_fifo.sv
`timescale 1ns/1ps

// Small circular FIFO buffering FE commands with a ready-then-valid write side
// The consumer takes the head with yumi_i while v_o is high

module fe_cmd_fifo
  #(parameter int fifo_els_p = 2)
  (input                         clk_i
   , input                       reset_i
   , input fe_cmd_pkg::fe_cmd_s  data_i
   , input                       v_i
   , output logic                ready_o
   , output fe_cmd_pkg::fe_cmd_s data_o
   , output logic                v_o
   , input                       yumi_i
   );

  import fe_cmd_pkg::*;

  localparam int ptr_width_lp = $clog2(fifo_els_p);

  // Extra top bit flips on every wrap to tell full from empty
  logic [ptr_width_lp:0]   wr_ptr_r;
  logic [ptr_width_lp:0]   rd_ptr_r;
  fe_cmd_s                 mem_r [fifo_els_p];
  logic                    empty;
  logic                    full;
  logic                    enq;
  logic                    deq;

  assign empty = (wr_ptr_r == rd_ptr_r);
  assign full  = (wr_ptr_r[ptr_width_lp] != rd_ptr_r[ptr_width_lp])
               & (wr_ptr_r[ptr_width_lp-1:0] == rd_ptr_r[ptr_width_lp-1:0]);

  // Ready comes from the pointers only, never from yumi_i
  assign ready_o = ~full;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rd_ptr_r[ptr_width_lp-1:0]];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (deq)
        rd_ptr_r <= rd_ptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r[ptr_width_lp-1:0]] <= data_i;
  end

  a_no_write_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> ready_o);

  a_no_yumi_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

//--- logic/be_director_top.sv
`timescale 1ns/1ps

// Back-end director for NPC tracking, issue poisoning and the command stream to the FE
// boot_pc_p and fifo_els_p are set here and passed down to the tracker and the FIFO

module be_director_top
  #(parameter logic [be_pkt_pkg::vaddr_width_c-1:0] boot_pc_p = 39'h0080000000
    , parameter int fifo_els_p = 2
    )
  (input                                          clk_i
   , input                                        reset_i
   , input                                        freeze_i
   , input                                        irq_waiting_i
   , input be_pkt_pkg::branch_pkt_s               br_pkt_i
   , input be_pkt_pkg::commit_pkt_s               commit_pkt_i
   , input be_pkt_pkg::isd_status_s               isd_status_i
   , input                                        fe_cmd_yumi_i
   , output logic [be_pkt_pkg::vaddr_width_c-1:0] expected_npc_o
   , output logic                                 poison_isd_o
   , output logic                                 suppress_iss_o
   , output fe_cmd_pkg::fe_cmd_s                  fe_cmd_o
   , output logic                                 fe_cmd_v_o
   , output logic                                 fe_cmd_full_o
   );

  import fe_cmd_pkg::*;

  logic    last_branch;
  logic    last_btaken;
  logic    fifo_ready;
  fe_cmd_s arb_cmd;
  logic    arb_cmd_v;

  npc_tracker
   #(.boot_pc_p(boot_pc_p))
   tracker
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .br_pkt_i(br_pkt_i)
     , .commit_pkt_i(commit_pkt_i)
     , .isd_status_i(isd_status_i)
     , .expected_npc_o(expected_npc_o)
     , .npc_mismatch_o(poison_isd_o)
     , .last_branch_o(last_branch)
     , .last_btaken_o(last_btaken)
     );

  cmd_arbiter
   arbiter
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .freeze_i(freeze_i)
     , .irq_waiting_i(irq_waiting_i)
     , .commit_pkt_i(commit_pkt_i)
     , .isd_status_i(isd_status_i)
     , .expected_npc_i(expected_npc_o)
     , .npc_mismatch_i(poison_isd_o)
     , .last_branch_i(last_branch)
     , .last_btaken_i(last_btaken)
     , .fifo_ready_i(fifo_ready)
     , .fe_cmd_v_i(fe_cmd_v_o)
     , .cmd_o(arb_cmd)
     , .cmd_v_o(arb_cmd_v)
     , .suppress_iss_o(suppress_iss_o)
     );

  fe_cmd_fifo
   #(.fifo_els_p(fifo_els_p))
   cmd_fifo
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .data_i(arb_cmd)
     , .v_i(arb_cmd_v)
     , .ready_o(fifo_ready)
     , .data_o(fe_cmd_o)
     , .v_o(fe_cmd_v_o)
     , .yumi_i(fe_cmd_yumi_i)
     );

  assign fe_cmd_full_o = ~fifo_ready;

endmodule

//--- verif/tb_director.sv
`timescale 1ns/1ps

// Testbench for the back-end director with a reference model that predicts every FE command
// Stimulus covers boot, mispredicts, attaboys, commit events, wait and FIFO back-pressure

module tb_director;

  import be_pkt_pkg::*;
  import fe_cmd_pkg::*;

  localparam logic [vaddr_width_c-1:0] boot_pc_c = 39'h0080000000;
  localparam int fifo_els_c = 2;
  localparam int timeout_c  = 50;

  // Model states of the director FSM
  localparam int st_reset = 0;
  localparam int st_boot  = 1;
  localparam int st_run   = 2;
  localparam int st_fence = 3;
  localparam int st_wait  = 4;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     freeze;
  logic                     irq_waiting;
  branch_pkt_s              br_pkt;
  commit_pkt_s              commit_pkt;
  isd_status_s              isd_status;
  logic                     fe_cmd_yumi;
  logic [vaddr_width_c-1:0] expected_npc;
  logic                     poison_isd;
  logic                     suppress_iss;
  fe_cmd_s                  fe_cmd;
  logic                     fe_cmd_v;
  logic                     fe_cmd_full;

  integer                   seed = 58;
  logic                     yumi_en;
  int                       n_seen;
  fe_cmd_s                  last_cmd;
  fe_cmd_s                  exp_q [$];

  // Reference model state
  int                       m_state;
  int                       m_count;
  logic [vaddr_width_c-1:0] m_npc;
  logic                     m_pend_b;
  logic                     m_pend_t;

  be_director_top
   #(.boot_pc_p(boot_pc_c)
     , .fifo_els_p(fifo_els_c)
     )
   uut
    (.clk_i(clk)
     , .reset_i(reset)
     , .freeze_i(freeze)
     , .irq_waiting_i(irq_waiting)
     , .br_pkt_i(br_pkt)
     , .commit_pkt_i(commit_pkt)
     , .isd_status_i(isd_status)
     , .fe_cmd_yumi_i(fe_cmd_yumi)
     , .expected_npc_o(expected_npc)
     , .poison_isd_o(poison_isd)
     , .suppress_iss_o(suppress_iss)
     , .fe_cmd_o(fe_cmd)
     , .fe_cmd_v_o(fe_cmd_v)
     , .fe_cmd_full_o(fe_cmd_full)
     );

  always #50 clk = ~clk;

  task automatic fail_and_stop();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_cmd(input fe_cmd_s got, input fe_cmd_s exp);
    if (got !== exp)
    begin
      $display("ERR fe_cmd_o got %h exp %h", got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_npc(input string name, input logic [vaddr_width_c-1:0] got,
                           input logic [vaddr_width_c-1:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      fail_and_stop();
    end
  endtask

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [vaddr_width_c-1:0] rand_vaddr();
    logic [63:0] r;
    r = {rand_word(), rand_word()};
    return {r[vaddr_width_c-1:2], 2'b00};
  endfunction

  // Expected command for one cycle
  // sel is low when no command is wanted
  function automatic fe_cmd_s exp_cmd(input int state, input commit_pkt_s c,
                                      input isd_status_s s, input logic [vaddr_width_c-1:0] npc,
                                      input logic mismatch, input logic lb, input logic lt,
                                      input logic irq, output logic sel);
    fe_cmd_s       cmd;
    redirect_ops_s ops;
    cmd = '0;
    ops = '0;
    sel = 1'b1;
    if (state == st_reset)
      sel = 1'b0;
    else if (state == st_boot)
    begin
      cmd.opcode = e_op_state_reset;
      cmd.vaddr  = npc;
      ops.priv   = c.priv_n;
      cmd.operands.redirect = ops;
    end
    else if (c.wfi | c.fencei | c.icache_miss)
    begin
      cmd.opcode = c.wfi ? e_op_wait : (c.fencei ? e_op_icache_fence : e_op_icache_fill_response);
      cmd.vaddr  = c.npc;
    end
    else if (c.eret | c.exception | c.interrupt | ((state == st_wait) & irq))
    begin
      cmd.opcode = e_op_pc_redirection;
      cmd.vaddr  = c.npc;
      ops.subop  = c.eret ? e_subop_eret : e_subop_trap;
      ops.priv   = c.priv_n;
      cmd.operands.redirect = ops;
    end
    else if (mismatch)
    begin
      cmd.opcode = e_op_pc_redirection;
      cmd.vaddr  = npc;
      ops.subop  = e_subop_branch_mispredict;
      ops.reason = !lb ? e_not_a_branch : (lt ? e_incorrect_pred_taken : e_incorrect_pred_ntaken);
      ops.bmeta  = s.bmeta;
      cmd.operands.redirect = ops;
    end
    else if (s.v & lb)
    begin
      cmd.opcode = e_op_attaboy;
      cmd.vaddr  = npc;
      cmd.operands.attaboy.taken = lt;
      cmd.operands.attaboy.bmeta = s.bmeta;
    end
    else
      sel = 1'b0;
    return cmd;
  endfunction

  // Model runs mid-cycle once inputs and DUT outputs have settled
  always @(posedge clk)
  begin
    logic [vaddr_width_c-1:0] exp_npc;
    logic                     mismatch;
    logic                     last_b;
    logic                     last_t;
    logic                     sel;
    logic                     enq;
    logic                     deq;
    fe_cmd_s                  cmd;
    #20;
    if (reset)
    begin
      m_state  = st_reset;
      m_count  = 0;
      m_npc    = boot_pc_c;
      m_pend_b = 1'b0;
      m_pend_t = 1'b0;
      exp_q.delete();
    end
    else
    begin
      exp_npc  = commit_pkt.npc_w_v ? commit_pkt.npc : (br_pkt.v ? br_pkt.npc : m_npc);
      mismatch = isd_status.v && (isd_status.pc != exp_npc);
      last_b   = m_pend_b | br_pkt.branch;
      last_t   = m_pend_t | br_pkt.btaken;
      check_npc("expected_npc_o", expected_npc, exp_npc);
      check_flag("poison_isd_o", poison_isd, mismatch);
      check_flag("fe_cmd_v_o", fe_cmd_v, m_count != 0);
      check_flag("fe_cmd_full_o", fe_cmd_full, m_count == fifo_els_c);
      check_flag("suppress_iss_o", suppress_iss,
                 ((m_state == st_fence) && (m_count != 0)) || (m_state == st_wait));
      cmd = exp_cmd(m_state, commit_pkt, isd_status, exp_npc, mismatch, last_b, last_t,
                    irq_waiting, sel);
      // Full FIFO drops the command
      enq = sel && (m_count < fifo_els_c);
      deq = fe_cmd_yumi && (m_count != 0);
      if (enq)
        exp_q.push_back(cmd);
      case (m_state)
        st_reset: m_state = freeze ? st_reset : st_boot;
        st_boot:  m_state = enq ? st_run : st_boot;
        st_run:   m_state = commit_pkt.wfi ? st_wait
                            : ((enq && cmd.opcode != e_op_attaboy) ? st_fence : st_run);
        st_fence: m_state = (m_count != 0) ? st_fence : st_run;
        st_wait:  m_state = (enq && cmd.opcode != e_op_attaboy) ? st_fence : st_wait;
        default:  m_state = st_reset;
      endcase
      m_count = m_count + (enq ? 1 : 0) - (deq ? 1 : 0);
      m_npc   = exp_npc;
      m_pend_b = isd_status.v ? 1'b0 : last_b;
      m_pend_t = isd_status.v ? 1'b0 : last_t;
    end
  end

  // Compare every command the FE takes against the model queue
  always @(negedge clk)
  begin
    if (!reset && fe_cmd_v && fe_cmd_yumi)
    begin
      if (exp_q.size() == 0)
      begin
        $display("A command left the FIFO while the model expected none");
        fail_and_stop();
      end
      else
      begin
        check_cmd(fe_cmd, exp_q.pop_front());
        last_cmd = fe_cmd;
        n_seen++;
      end
    end
  end

  // FE side takes commands with random gaps
  always @(posedge clk)
  begin
    logic [31:0] gap;
    #5;
    gap = rand_word();
    fe_cmd_yumi = yumi_en && (fe_cmd_v === 1'b1) && (gap[1:0] != 2'b00);
  end

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic clear_inputs();
    br_pkt            = '0;
    commit_pkt        = '0;
    commit_pkt.priv_n = e_priv_machine;
    isd_status        = '0;
    irq_waiting       = 1'b0;
  endtask

  task automatic wait_seen(input int target);
    int cycles;
    cycles = 0;
    while (n_seen < target && cycles < timeout_c)
    begin
      next_cycle();
      cycles++;
    end
    if (n_seen < target)
    begin
      $display("Timed out waiting for FE command number %0d", target);
      fail_and_stop();
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || fe_cmd_v) && cycles < timeout_c)
    begin
      next_cycle();
      cycles++;
    end
    if (exp_q.size() != 0 || fe_cmd_v)
    begin
      $display("Timed out waiting for the FE command FIFO to drain");
      fail_and_stop();
    end
  endtask

  task automatic wait_suppress_low();
    int cycles;
    cycles = 0;
    while (suppress_iss && cycles < timeout_c)
    begin
      next_cycle();
      cycles++;
    end
    if (suppress_iss)
    begin
      $display("Timed out waiting for issue suppression to end");
      fail_and_stop();
    end
  endtask

  initial
  begin
    logic [31:0]              w;
    logic [vaddr_width_c-1:0] tgt;
    logic                     taken;
    int                       base;
    int                       ev;
    reset       = 1'b1;
    freeze      = 1'b1;
    yumi_en     = 1'b0;
    fe_cmd_yumi = 1'b0;
    n_seen      = 0;
    clear_inputs();
    repeat (8) @(posedge clk);
    #5;
    reset = 1'b0;

    // Boot with nothing coming out while frozen
    repeat (4)
    begin
      next_cycle();
      #10 check_flag("fe_cmd_v_o", fe_cmd_v, 1'b0);
    end
    freeze  = 1'b0;
    yumi_en = 1'b1;
    wait_seen(1);
    check_flag("boot opcode is state_reset", last_cmd.opcode == e_op_state_reset, 1'b1);
    check_npc("boot vaddr", last_cmd.vaddr, boot_pc_c);
    wait_drain();

    // Mispredicts where the issue PC misses the resolved NPC
    repeat (6)
    begin
      w   = rand_word();
      tgt = rand_vaddr();
      br_pkt.v      = 1'b1;
      br_pkt.npc    = tgt;
      br_pkt.branch = w[0];
      br_pkt.btaken = w[0] & w[1];
      next_cycle();
      clear_inputs();
      isd_status.v     = 1'b1;
      isd_status.pc    = tgt + 39'd4;
      isd_status.bmeta = w[31:16];
      #10 check_flag("poison_isd_o", poison_isd, 1'b1);
      next_cycle();
      clear_inputs();
      wait_drain();
    end

    // Correct predictions
    repeat (4)
    begin
      w     = rand_word();
      tgt   = rand_vaddr();
      taken = w[2];
      br_pkt.v      = 1'b1;
      br_pkt.npc    = tgt;
      br_pkt.branch = 1'b1;
      br_pkt.btaken = taken;
      next_cycle();
      clear_inputs();
      isd_status.v     = 1'b1;
      isd_status.pc    = tgt;
      isd_status.bmeta = w[31:16];
      #10 check_flag("poison_isd_o", poison_isd, 1'b0);
      next_cycle();
      clear_inputs();
      wait_drain();
      check_flag("attaboy opcode", last_cmd.opcode == e_op_attaboy, 1'b1);
      check_flag("attaboy taken", last_cmd.operands.attaboy.taken, taken);
    end

    // Commit events one at a time or two together
    repeat (8)
    begin
      w  = rand_word();
      ev = int'(w[7:0]) % 6;
      commit_pkt.npc_w_v = 1'b1;
      commit_pkt.npc     = rand_vaddr();
      case (ev)
        0: commit_pkt.eret = 1'b1;
        1: commit_pkt.exception = 1'b1;
        2: commit_pkt.interrupt = 1'b1;
        3: commit_pkt.fencei = 1'b1;
        4: commit_pkt.icache_miss = 1'b1;
        default:
        begin
          commit_pkt.eret   = 1'b1;
          commit_pkt.fencei = 1'b1;
        end
      endcase
      next_cycle();
      clear_inputs();
      wait_drain();
    end

    // Wait for interrupt and wake up on a waiting irq
    base = n_seen;
    commit_pkt.npc_w_v = 1'b1;
    commit_pkt.npc     = rand_vaddr();
    commit_pkt.wfi     = 1'b1;
    next_cycle();
    clear_inputs();
    repeat (3)
    begin
      #10 check_flag("suppress_iss_o", suppress_iss, 1'b1);
      next_cycle();
    end
    irq_waiting = 1'b1;
    next_cycle();
    clear_inputs();
    wait_seen(base + 2);
    wait_suppress_low();
    wait_drain();

    // Back-pressure where only the first fifo_els_c commands survive
    yumi_en = 1'b0;
    base    = n_seen;
    for (int i = 0; i < 4; i++)
    begin
      commit_pkt.npc_w_v     = 1'b1;
      commit_pkt.npc         = rand_vaddr();
      commit_pkt.fencei      = (i == 0);
      commit_pkt.icache_miss = (i == 1);
      commit_pkt.eret        = (i == 2);
      commit_pkt.exception   = (i == 3);
      next_cycle();
    end
    clear_inputs();
    #10 check_flag("fe_cmd_full_o", fe_cmd_full, 1'b1);
    next_cycle();
    yumi_en = 1'b1;
    wait_seen(base + fifo_els_c);
    wait_drain();

    $display("No errors");
    $finish;
  end

endmodule

//--- filelist.f
logic/be_pkt_pkg.sv
logic/fe_cmd_pkg.sv
logic/npc_tracker.sv
logic/cmd_arbiter.sv
logic/fe_cmd_fifo.sv
logic/be_director_top.sv
verif/tb_director.sv

//--- run_sim.sh
#!/bin/sh
# Builds the director testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_director

status=0
./obj_dir/Vtb_director > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation PASSED"
